/* project.f */
source/cpu_pkg.sv
source/decoder_complex.sv
source/microcode_rom.sv
source/micro_sequencer.sv
source/program_counter.sv
source/alu_accumulator.sv
source/apb_memory.sv
source/cpu_top.sv
tb/cpu_props.sv
tb/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = cpu_tb
FILELIST = project.f
BUILD = obj_dir
LOG = sim.log
PASS_MSG = RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;
	import cpu_pkg::*;

	localparam logic [7:0] reset_vector = 8'h00;
	localparam int num_tests = 6;
	localparam int poll_limit = 1000;

	// operation kinds of the ISA model
	localparam int mop_add = 0;
	localparam int mop_sub = 1;
	localparam int mop_xor = 2;
	localparam int mop_nor = 3;
	localparam int mop_nand = 4;
	localparam int mop_inc = 5;
	localparam int mop_inv = 6;
	localparam int mop_asl = 7;
	localparam int mop_asr = 8;

	// branch cases, each opcode once taken and once not taken
	localparam logic [7:0] branch_op [0:9] = '{8'h04, 8'h04, 8'h09, 8'h09, 8'h0a,
		8'h0a, 8'h70, 8'h70, 8'h71, 8'h71};
	localparam logic [7:0] branch_val [0:9] = '{8'h80, 8'h01, 8'h01, 8'h80, 8'h00,
		8'h05, 8'hff, 8'h01, 8'h7f, 8'h01};
	localparam logic [7:0] branch_imm [0:9] = '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
		8'h00, 8'h01, 8'h01, 8'h01, 8'h01};

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [apb_addr_width-1:0] paddr;
	logic [apb_data_width-1:0] pwdata;
	logic [apb_data_width-1:0] prdata;
	logic pready;
	logic pslverr;

	int seed;
	int errors;
	int errors_at_start;
	int test_num;
	int tests_failed;
	int pos;

	// image of the DUT memory as the host believes it to be
	logic [7:0] img [0:255];
	// ISA model state, acc and flags carry over between runs like the core's
	logic [7:0] m_mem [0:255];
	logic [7:0] m_acc;
	logic [fwidth-1:0] m_flags;

	cpu_top #(.reset_vector(reset_vector)) dut (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #10 clk = ~clk;

	// ########################################################################
	// checks and bookkeeping
	// ########################################################################

	task automatic expect_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		assert (got === exp)
		else begin
			$display("FAIL %0t ns %s: expected %h, got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		assert (cond === 1'b1)
		else begin
			$display("ERROR %0t ns %s", $time, what);
			errors++;
		end
	endtask

	task automatic begin_test();
		test_num++;
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		if (errors == errors_at_start)
			$display("test %0d %s: passed", test_num, name);
		else begin
			$display("test %0d %s: failed with %0d errors", test_num, name,
				errors - errors_at_start);
			tests_failed++;
		end
	endtask

	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// ########################################################################
	// APB host, setup cycle then access cycle
	// ########################################################################

	task automatic apb_access(input logic wr, input logic [11:0] addr,
			input logic [31:0] wdata, input logic exp_err, output logic [31:0] rdata);
		int waits;
		@(posedge clk);
		#2;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#2;
		penable = 1'b1;
		waits = 0;
		// sample mid cycle where the combinational response has settled
		@(negedge clk);
		while (pready !== 1'b1 && waits < 8) begin
			@(negedge clk);
			waits++;
		end
		expect_true(pready, "pready stayed low in the APB access phase");
		expect_value("pslverr", {31'h0, exp_err}, {31'h0, pslverr});
		rdata = prdata;
		@(posedge clk);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
			input logic exp_err);
		logic [31:0] unused;
		apb_access(1'b1, addr, data, exp_err, unused);
	endtask

	task automatic apb_read(input logic [11:0] addr, input logic exp_err,
			output logic [31:0] data);
		apb_access(1'b0, addr, 32'h0, exp_err, data);
	endtask

	task automatic load_image(input int lo, input int hi);
		int a;
		for (a = lo; a <= hi; a++)
			apb_write(a[11:0], {24'h0, img[a[7:0]]}, 1'b0);
	endtask

	task automatic compare_mem(input int lo, input int hi);
		int a;
		logic [31:0] d;
		for (a = lo; a <= hi; a++) begin
			apb_read(a[11:0], 1'b0, d);
			expect_value($sformatf("mem[%02h]", a[7:0]), {24'h0, img[a[7:0]]}, d);
		end
	endtask

	// ########################################################################
	// program assembly and ISA model
	// ########################################################################

	task automatic emit(input logic [7:0] b);
		img[pos[7:0]] = b;
		pos++;
	endtask

	task automatic emit2(input logic [7:0] op, input logic [7:0] arg);
		emit(op);
		emit(arg);
	endtask

	// one ALU instruction, compares keep the accumulator
	task automatic alu_model(input int kind, input logic [7:0] b, input logic write_acc);
		logic [7:0] r;
		logic c;
		logic v;
		c = 1'b0;
		v = 1'b0;
		case (kind)
			mop_add: begin
				r = m_acc + b;
				// a wrapped sum is smaller than the accumulator
				c = (r < m_acc);
				v = (m_acc[7] == b[7]) && (r[7] != b[7]);
			end
			mop_sub: begin
				r = m_acc - b;
				c = (m_acc < b);
				v = (m_acc[7] != b[7]) && (r[7] == b[7]);
			end
			mop_xor: r = m_acc ^ b;
			mop_nor: r = ~(m_acc | b);
			mop_nand: r = ~(m_acc & b);
			mop_inc: begin
				r = m_acc + 8'd1;
				c = (m_acc == 8'hff);
			end
			mop_inv: r = ~m_acc;
			mop_asl: begin
				r = m_acc << 1;
				c = m_acc[7];
			end
			mop_asr: r = {m_acc[7], m_acc[7:1]};
			default: r = 8'h00;
		endcase
		m_flags[negative_flag] = r[7];
		m_flags[zero_flag] = (r == 8'h00);
		m_flags[carry_flag] = c;
		m_flags[overflow_flag] = v;
		if (write_acc)
			m_acc = r;
	endtask

	// runs the image from the reset vector until an undefined opcode
	task automatic run_model();
		logic [7:0] pc;
		logic [7:0] next_pc;
		logic [7:0] op;
		logic [7:0] arg;
		logic taken;
		logic done;
		int steps;
		m_mem = img;
		pc = reset_vector;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 100000) begin
			op = m_mem[pc];
			arg = m_mem[pc + 8'd1];
			next_pc = pc + 8'd2;
			if (op inside {8'h0d, 8'h0e, 8'h72, 8'h75, 8'h7e})
				next_pc = pc + 8'd1;
			taken = (op == 8'h03)
				|| (op == 8'h04 && m_flags[negative_flag])
				|| (op == 8'h09 && !m_flags[negative_flag])
				|| (op == 8'h0a && m_flags[zero_flag])
				|| (op == 8'h70 && m_flags[carry_flag])
				|| (op == 8'h71 && m_flags[overflow_flag]);
			case (op)
				8'h00: alu_model(mop_add, m_mem[arg], 1'b1);
				8'h01: m_mem[arg] = m_acc;
				8'h02: m_acc = m_mem[arg];
				8'h03, 8'h04, 8'h09, 8'h0a, 8'h70, 8'h71:
					if (taken)
						next_pc = arg;
				8'h05: alu_model(mop_sub, m_mem[arg], 1'b1);
				8'h06: alu_model(mop_xor, m_mem[arg], 1'b1);
				8'h07: alu_model(mop_nor, m_mem[arg], 1'b1);
				8'h08: alu_model(mop_nand, m_mem[arg], 1'b1);
				8'h0b: alu_model(mop_add, arg, 1'b1);
				8'h0d: alu_model(mop_asl, 8'h00, 1'b1);
				8'h0e: alu_model(mop_asr, 8'h00, 1'b1);
				8'h72: alu_model(mop_inc, 8'h00, 1'b1);
				8'h73: alu_model(mop_sub, arg, 1'b0);
				8'h74: alu_model(mop_sub, m_mem[arg], 1'b0);
				8'h75: alu_model(mop_inv, 8'h00, 1'b1);
				8'h7e: m_acc = 8'h00;
				8'h7f: m_acc = arg;
				default: done = 1'b1;
			endcase
			pc = next_pc;
			steps++;
		end
	endtask

	// ########################################################################
	// core control
	// ########################################################################

	task automatic start_core();
		apb_write(reg_ctrl, 32'h1, 1'b0);
	endtask

	task automatic wait_halt();
		logic [31:0] d;
		int polls;
		polls = 0;
		d = 32'h0;
		while (d[1] !== 1'b1 && polls < poll_limit) begin
			apb_read(reg_ctrl, 1'b0, d);
			polls++;
		end
		expect_true(d[1], "core did not halt within the poll limit");
		// halted with running low
		expect_value("ctrl", 32'h2, d);
	endtask

	task automatic check_result();
		logic [31:0] d;
		apb_read(reg_acc, 1'b0, d);
		expect_value("acc", {24'h0, m_acc}, d);
		apb_read(reg_flags, 1'b0, d);
		expect_value("flags", {28'h0, m_flags}, d);
		img = m_mem;
	endtask

	task automatic run_program();
		run_model();
		start_core();
		wait_halt();
		check_result();
	endtask

	// ########################################################################
	// tests
	// ########################################################################

	initial begin
		logic [31:0] d;
		logic [7:0] base;
		logic [7:0] a_val;
		int i;
		seed = 32'h0512_1183;
		errors = 0;
		errors_at_start = 0;
		test_num = 0;
		tests_failed = 0;
		pos = 0;
		m_acc = 8'h00;
		m_flags = '0;
		clk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;

		// registers come out of reset cleared, unmapped addresses error
		begin_test();
		apb_read(reg_ctrl, 1'b0, d);
		expect_value("ctrl", 32'h0, d);
		apb_read(reg_acc, 1'b0, d);
		expect_value("acc", 32'h0, d);
		apb_read(reg_flags, 1'b0, d);
		expect_value("flags", 32'h0, d);
		apb_read(12'h10c, 1'b1, d);
		end_test("reset values");

		begin_test();
		for (i = 0; i < 256; i++)
			img[i[7:0]] = rand_byte();
		load_image(0, 255);
		compare_mem(0, 255);
		// 256 increments until the accumulator wraps to zero
		pos = 0;
		emit2(8'h7f, 8'h00);
		emit(8'h72);
		emit2(8'h0a, 8'h07);
		emit2(8'h03, 8'h02);
		emit(8'h0c);
		load_image(0, 7);
		run_model();
		start_core();
		apb_read(reg_ctrl, 1'b0, d);
		expect_value("ctrl", 32'h1, d);
		apb_read(12'h010, 1'b1, d);
		apb_write(12'h020, {24'h0, ~img[8'h20]}, 1'b1);
		apb_read(reg_acc, 1'b1, d);
		apb_read(reg_flags, 1'b1, d);
		apb_read(12'h200, 1'b1, d);
		wait_halt();
		check_result();
		// the rejected write must not have reached memory
		compare_mem('h20, 'h20);
		end_test("memory access and error response");

		begin_test();
		pos = 0;
		emit2(8'h7f, rand_byte());
		emit2(8'h02, 8'h80);
		emit2(8'h00, 8'h81);
		emit2(8'h05, 8'h82);
		emit2(8'h06, 8'h83);
		emit2(8'h07, 8'h84);
		emit2(8'h08, 8'h85);
		emit2(8'h0b, rand_byte());
		emit(8'h72);
		emit(8'h75);
		emit(8'h0d);
		emit(8'h0e);
		emit2(8'h01, 8'h90);
		emit(8'h0c);
		for (i = 'h80; i <= 'h85; i++)
			img[i[7:0]] = rand_byte();
		load_image(0, pos - 1);
		load_image('h80, 'h85);
		run_program();
		compare_mem('h90, 'h90);
		end_test("ALU operations");

		// each block sets flags, branches and stores the marker of the path
		begin_test();
		pos = 0;
		for (i = 0; i < 10; i++) begin
			base = pos[7:0];
			emit2(8'h7f, branch_val[i[3:0]]);
			emit2(8'h0b, branch_imm[i[3:0]]);
			emit2(branch_op[i[3:0]], base + 8'd12);
			emit2(8'h7f, 8'h50 + i[7:0]);
			emit2(8'h01, 8'hc0 + i[7:0]);
			emit2(8'h03, base + 8'd16);
			emit2(8'h7f, 8'ha0 + i[7:0]);
			emit2(8'h01, 8'hc0 + i[7:0]);
		end
		emit(8'h0c);
		load_image(0, pos - 1);
		run_program();
		compare_mem('hc0, 'hc9);
		end_test("conditional branches");

		begin_test();
		a_val = rand_byte();
		pos = 0;
		emit2(8'h7f, a_val);
		emit2(8'h73, rand_byte());
		emit(8'h0c);
		load_image(0, pos - 1);
		run_program();
		pos = 0;
		emit(8'h7e);
		emit2(8'h01, 8'he0);
		emit2(8'h7f, rand_byte());
		emit2(8'h01, 8'he1);
		emit2(8'h7f, a_val);
		emit2(8'h74, 8'hd0);
		emit(8'h0c);
		img[8'hd0] = rand_byte();
		load_image(0, pos - 1);
		load_image('hd0, 'hd0);
		run_program();
		apb_read(reg_acc, 1'b0, d);
		expect_value("acc after compare", {24'h0, a_val}, d);
		compare_mem('he0, 'he1);
		end_test("compare, store, clear and load immediate");

		// the rerun must write the cleared byte again from the start
		begin_test();
		pos = 0;
		emit2(8'h7f, rand_byte());
		emit2(8'h0b, rand_byte());
		emit2(8'h01, 8'hf0);
		emit(8'h0c);
		load_image(0, pos - 1);
		run_program();
		img[8'hf0] = 8'h00;
		load_image('hf0, 'hf0);
		run_program();
		compare_mem('hf0, 'hf0);
		end_test("undefined opcode and restart");

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			test_num, tests_failed, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// budget of 2000 cycles per test
	initial begin
		repeat (num_tests * 2000) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", num_tests * 2000);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* tb/cpu_props.sv */
`timescale 1ns/100ps

module cpu_props (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic running,
	input logic halted,
	input logic mem_write
);

	// the slave answers only in the access phase of a transfer
	a_pready_access: assert property (@(posedge clk) disable iff (rst)
		pready |-> (psel && penable))
		else $error("pready outside an APB access phase");

	// an error response is only valid together with pready
	a_pslverr_ready: assert property (@(posedge clk) disable iff (rst)
		pslverr |-> pready)
		else $error("pslverr without pready");

	// the sequencer is in exactly one of idle, run or halt
	a_run_halt: assert property (@(posedge clk) disable iff (rst)
		!(running && halted))
		else $error("running and halted both high");

	// stores come only from microcode, so an idle core never writes
	a_write_idle: assert property (@(posedge clk) disable iff (rst)
		mem_write |-> running)
		else $error("memory write from a core that is not running");

	// reset leaves the core idle, neither running nor halted
	a_reset_idle: assert property (@(posedge clk)
		rst |=> (!running && !halted))
		else $error("core not idle after reset");

endmodule

bind cpu_top cpu_props props (
	.clk(clk),
	.rst(rst),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.pslverr(pslverr),
	.running(running),
	.halted(halted),
	.mem_write(mem_write)
);

/* source/cpu_top.sv */
`timescale 1ns/100ps

module cpu_top #(
	parameter logic [7:0] reset_vector = 8'h00
) (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cpu_pkg::apb_addr_width-1:0] paddr,
	input logic [cpu_pkg::apb_data_width-1:0] pwdata,
	output logic [cpu_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import cpu_pkg::*;

	logic start;
	logic running;
	logic halted;
	logic [7:0] mem_addr;
	logic [7:0] mem_rdata;
	logic mem_write;
	alu_op_e alu_op;
	logic acc_load;
	logic opr_load;
	logic flags_load;
	logic pc_inc;
	logic pc_load;
	logic [7:0] pc;
	logic [7:0] operand;
	logic [7:0] acc;
	logic [fwidth-1:0] flags;

	micro_sequencer u_seq (
		.clk(clk), .rst(rst), .start(start),
		.mem_rdata(mem_rdata), .flags(flags), .pc(pc), .operand(operand),
		.running(running), .halted(halted), .mem_addr(mem_addr),
		.alu_op(alu_op), .acc_load(acc_load), .opr_load(opr_load),
		.flags_load(flags_load), .mem_write(mem_write),
		.pc_inc(pc_inc), .pc_load(pc_load)
	);

	// a start also restarts the program counter, branches load the memory byte
	program_counter #(.reset_vector(reset_vector)) u_pc (
		.clk(clk), .rst(rst), .restart(start),
		.pc_inc(pc_inc), .pc_load(pc_load), .load_value(mem_rdata), .pc(pc)
	);

	alu_accumulator u_alu (
		.clk(clk), .rst(rst), .alu_op(alu_op),
		.acc_load(acc_load), .opr_load(opr_load), .flags_load(flags_load),
		.mem_rdata(mem_rdata), .operand(operand), .acc(acc), .flags(flags)
	);

	// stores always write the accumulator
	apb_memory u_mem (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.mem_addr(mem_addr), .mem_wdata(acc), .mem_write(mem_write),
		.mem_rdata(mem_rdata), .running(running), .halted(halted),
		.acc(acc), .flags(flags), .start(start)
	);

endmodule

/* source/apb_memory.sv */
`timescale 1ns/100ps

module apb_memory (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cpu_pkg::apb_addr_width-1:0] paddr,
	input logic [cpu_pkg::apb_data_width-1:0] pwdata,
	output logic [cpu_pkg::apb_data_width-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic [7:0] mem_addr,
	input logic [7:0] mem_wdata,
	input logic mem_write,
	output logic [7:0] mem_rdata,
	input logic running,
	input logic halted,
	input logic [7:0] acc,
	input logic [cpu_pkg::fwidth-1:0] flags,
	output logic start
);
	import cpu_pkg::*;

	logic [7:0] mem [0:255];
	logic access;
	logic in_mem;
	logic is_ctrl;
	logic is_acc;
	logic is_flags;
	logic host_ok;

	// ########################################################################
	// APB decode, zero wait states
	// ########################################################################

	assign access = psel && penable;
	assign in_mem = (paddr[apb_addr_width-1:8] == '0);
	assign is_ctrl = (paddr == reg_ctrl);
	assign is_acc = (paddr == reg_acc);
	assign is_flags = (paddr == reg_flags);

	// ctrl is always reachable, the rest only while the core is stopped
	assign host_ok = is_ctrl || (!running && (in_mem || is_acc || is_flags));

	assign pready = access;
	assign pslverr = access && !host_ok;

	always_comb begin
		prdata = '0;
		if (access && host_ok && !pwrite) begin
			if (in_mem)
				prdata[7:0] = mem[paddr[7:0]];
			else if (is_ctrl)
				prdata[1:0] = {halted, running};
			else if (is_acc)
				prdata[7:0] = acc;
			else
				prdata[fwidth-1:0] = flags;
		end
	end

	// ########################################################################
	// shared memory, the host port only works while the core is stopped
	// ########################################################################

	always_ff @(posedge clk) begin
		if (mem_write)
			mem[mem_addr] <= mem_wdata;
		else if (access && pwrite && in_mem && host_ok)
			mem[paddr[7:0]] <= pwdata[7:0];
	end

	assign mem_rdata = mem[mem_addr];

	// a start request to a running core is ignored
	always_ff @(posedge clk) begin
		if (rst)
			start <= 1'b0;
		else
			start <= access && pwrite && is_ctrl && pwdata[0] && !running && !start;
	end

endmodule

/* source/alu_accumulator.sv */
`timescale 1ns/100ps

module alu_accumulator (
	input logic clk,
	input logic rst,
	input cpu_pkg::alu_op_e alu_op,
	input logic acc_load,
	input logic opr_load,
	input logic flags_load,
	input logic [7:0] mem_rdata,
	output logic [7:0] operand,
	output logic [7:0] acc,
	output logic [cpu_pkg::fwidth-1:0] flags
);
	import cpu_pkg::*;

	logic [7:0] result;
	logic carry;
	logic overflow;

	// ########################################################################
	// ALU, accumulator against the memory byte
	// ########################################################################

	// carry and overflow stay clear unless an operation below sets them
	always_comb begin
		result = 8'h00;
		carry = 1'b0;
		overflow = 1'b0;
		case (alu_op)
			alu_pass_mem: result = mem_rdata;
			alu_add: begin
				{carry, result} = {1'b0, acc} + {1'b0, mem_rdata};
				// operands of equal sign giving a result of the other sign
				overflow = (acc[7] == mem_rdata[7]) && (result[7] != acc[7]);
			end
			// compare is a subtraction whose result is only used for flags
			alu_sub, alu_cmp: begin
				{carry, result} = {1'b0, acc} - {1'b0, mem_rdata};
				overflow = (acc[7] != mem_rdata[7]) && (result[7] != acc[7]);
			end
			alu_xor: result = acc ^ mem_rdata;
			alu_nor: result = ~(acc | mem_rdata);
			alu_nand: result = ~(acc & mem_rdata);
			alu_inc: {carry, result} = {1'b0, acc} + 9'd1;
			alu_inv: result = ~acc;
			// the bit leaving on the left goes to carry
			alu_asl: {carry, result} = {acc, 1'b0};
			// sign bit is kept, carry stays clear
			alu_asr: result = {acc[7], acc[7:1]};
			default: result = 8'h00;
		endcase
	end

	// ########################################################################
	// registers
	// ########################################################################

	always_ff @(posedge clk) begin
		if (rst) begin
			acc <= 8'h00;
			flags <= '0;
		end else begin
			if (acc_load)
				acc <= result;
			if (flags_load) begin
				flags[negative_flag] <= result[7];
				flags[zero_flag] <= (result == 8'h00);
				flags[carry_flag] <= carry;
				flags[overflow_flag] <= overflow;
			end
		end
	end

	// operand byte used as a memory address by the second routine word
	always_ff @(posedge clk) begin
		if (opr_load)
			operand <= mem_rdata;
	end

endmodule

/* source/program_counter.sv */
`timescale 1ns/100ps

module program_counter #(
	parameter logic [7:0] reset_vector = 8'h00
) (
	input logic clk,
	input logic rst,
	input logic restart,
	input logic pc_inc,
	input logic pc_load,
	input logic [7:0] load_value,
	output logic [7:0] pc
);

	// a start reloads the vector so a rerun begins where the first run did,
	// a branch load wins over the step and the counter wraps at 0xff
	always_ff @(posedge clk) begin
		if (rst || restart)
			pc <= reset_vector;
		else if (pc_load)
			pc <= load_value;
		else if (pc_inc)
			pc <= pc + 8'd1;
	end

endmodule

/* source/micro_sequencer.sv */
`timescale 1ns/100ps

module micro_sequencer (
	input logic clk,
	input logic rst,
	input logic start,
	input logic [7:0] mem_rdata,
	input logic [cpu_pkg::fwidth-1:0] flags,
	input logic [7:0] pc,
	input logic [7:0] operand,
	output logic running,
	output logic halted,
	output logic [7:0] mem_addr,
	output cpu_pkg::alu_op_e alu_op,
	output logic acc_load,
	output logic opr_load,
	output logic flags_load,
	output logic mem_write,
	output logic pc_inc,
	output logic pc_load
);
	import cpu_pkg::*;

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_run = 2'd1;
	localparam logic [1:0] st_halt = 2'd2;

	logic [1:0] state;
	logic [mc_offset_width-1:0] mc_pc;
	logic [mc_offset_width-1:0] dispatch_offset;
	logic [7:0] opcode;
	mc_word_t mc_word;
	logic ctrl_en;

	decoder_complex u_decoder (
		.opcode(opcode),
		.flags(flags),
		.op_decoder_out(dispatch_offset)
	);

	microcode_rom u_rom (
		.mc_addr(mc_pc),
		.mc_word(mc_word)
	);

	// ########################################################################
	// run control and micro-program counter
	// ########################################################################

	// start only arrives while the core is not running, and it rearms
	// both idle and halted cores at the fetch entry
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			mc_pc <= mc_fetch;
		end else if (start) begin
			state <= st_run;
			mc_pc <= mc_fetch;
		end else if (state == st_run) begin
			if (!mc_word.mc_ctrl.mc_is_seq) begin
				if (mc_word.mc_ctrl.end_instr)
					mc_pc <= mc_fetch;
				else
					mc_pc <= mc_pc + 1'b1;
			end else begin
				case (mc_word.mc_seq.seq_kind)
					seq_dispatch: mc_pc <= dispatch_offset;
					seq_jump: mc_pc <= mc_word.mc_seq.target;
					// halt word, running drops on this edge
					default: state <= st_halt;
				endcase
			end
		end
	end

	// the fetch word reads the opcode byte at the program counter
	always_ff @(posedge clk) begin
		if (state == st_run && mc_pc == mc_fetch)
			opcode <= mem_rdata;
	end

	assign running = (state == st_run);
	assign halted = (state == st_halt);

	// controls are quiet on sequencing words and outside run
	assign ctrl_en = running && !mc_word.mc_ctrl.mc_is_seq;
	assign alu_op = ctrl_en ? mc_word.mc_ctrl.alu_op : alu_pass_mem;
	assign acc_load = ctrl_en && mc_word.mc_ctrl.acc_load;
	assign opr_load = ctrl_en && mc_word.mc_ctrl.opr_load;
	assign flags_load = ctrl_en && mc_word.mc_ctrl.flags_load;
	assign mem_write = ctrl_en && mc_word.mc_ctrl.mem_write;
	assign pc_inc = ctrl_en && mc_word.mc_ctrl.pc_inc;
	assign pc_load = ctrl_en && mc_word.mc_ctrl.pc_load;

	// memory address comes from the operand register or the program counter
	assign mem_addr = (ctrl_en && mc_word.mc_ctrl.mem_addr_sel) ? operand : pc;

endmodule

/* source/microcode_rom.sv */
`timescale 1ns/100ps

module microcode_rom (
	input logic [5:0] mc_addr,
	output cpu_pkg::mc_word_t mc_word
);
	import cpu_pkg::*;

	// strobe bits in the order of the control view, acc_load first
	localparam logic [7:0] s_acc = 8'h80;
	localparam logic [7:0] s_opr = 8'h40;
	localparam logic [7:0] s_flg = 8'h20;
	localparam logic [7:0] s_opa = 8'h10;
	localparam logic [7:0] s_wr = 8'h08;
	localparam logic [7:0] s_inc = 8'h04;
	localparam logic [7:0] s_ld = 8'h02;
	localparam logic [7:0] s_end = 8'h01;

	function automatic mc_word_t ctl(input alu_op_e op, input logic [7:0] strobes);
		mc_word_t w;
		w = '0;
		w.mc_ctrl.alu_op = op;
		{w.mc_ctrl.acc_load, w.mc_ctrl.opr_load, w.mc_ctrl.flags_load,
			w.mc_ctrl.mem_addr_sel, w.mc_ctrl.mem_write, w.mc_ctrl.pc_inc,
			w.mc_ctrl.pc_load, w.mc_ctrl.end_instr} = strobes;
		return w;
	endfunction

	function automatic mc_word_t seq(input logic [1:0] kind, input logic [5:0] target);
		mc_word_t w;
		w = '0;
		w.mc_seq.mc_is_seq = 1'b1;
		w.mc_seq.seq_kind = kind;
		w.mc_seq.target = target;
		return w;
	endfunction

	// memory operand routines take two words, the first latches the
	// operand byte as an address and steps past it, the second uses
	// the operand register as memory address
	always_comb begin
		case (mc_addr)
			mc_fetch:            mc_word = ctl(alu_pass_mem, s_inc);
			mc_dispatch:         mc_word = seq(seq_dispatch, mc_fetch);
			mc_clear:            mc_word = ctl(alu_clear, s_acc | s_end);
			mc_load_imm:         mc_word = ctl(alu_pass_mem, s_acc | s_inc | s_end);
			mc_load:             mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_load + 6'd1:      mc_word = ctl(alu_pass_mem, s_opa | s_acc | s_end);
			mc_store:            mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_store + 6'd1:     mc_word = ctl(alu_pass_mem, s_opa | s_wr | s_end);
			mc_add:              mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_add + 6'd1:       mc_word = ctl(alu_add, s_opa | s_acc | s_flg | s_end);
			// the program counter sits on the target byte at this point
			mc_taken:            mc_word = ctl(alu_pass_mem, s_ld | s_end);
			mc_not_taken:        mc_word = ctl(alu_pass_mem, s_inc | s_end);
			mc_inc:              mc_word = ctl(alu_inc, s_acc | s_flg | s_end);
			// compares update the flags only
			mc_cmp_imm:          mc_word = ctl(alu_cmp, s_flg | s_inc | s_end);
			mc_cmp:              mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_cmp + 6'd1:       mc_word = ctl(alu_cmp, s_opa | s_flg | s_end);
			mc_sub:              mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_sub + 6'd1:       mc_word = ctl(alu_sub, s_opa | s_acc | s_flg | s_end);
			mc_xor:              mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_xor + 6'd1:       mc_word = ctl(alu_xor, s_opa | s_acc | s_flg | s_end);
			mc_nor:              mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_nor + 6'd1:       mc_word = ctl(alu_nor, s_opa | s_acc | s_flg | s_end);
			mc_nand:             mc_word = ctl(alu_pass_mem, s_opr | s_inc);
			mc_nand + 6'd1:      mc_word = ctl(alu_nand, s_opa | s_acc | s_flg | s_end);
			mc_add_imm:          mc_word = ctl(alu_add, s_acc | s_flg | s_inc | s_end);
			mc_inv:              mc_word = ctl(alu_inv, s_acc | s_flg | s_end);
			mc_asr:              mc_word = ctl(alu_asr, s_acc | s_flg | s_end);
			mc_asl:              mc_word = ctl(alu_asl, s_acc | s_flg | s_end);
			mc_halt:             mc_word = seq(seq_halt, mc_halt);
			// unused slots fall through to the halt entry
			default:             mc_word = seq(seq_jump, mc_halt);
		endcase
	end

endmodule

/* source/decoder_complex.sv */
`timescale 1ns/100ps

module decoder_complex (
	input logic [7:0] opcode,
	input logic [cpu_pkg::fwidth-1:0] flags,
	output logic [cpu_pkg::mc_offset_width-1:0] op_decoder_out
);
	import cpu_pkg::*;

	// conditional branches resolve here, so the taken and not-taken
	// routines never look at the flags themselves
	always_comb begin
		case (opcode)
			// add the byte at the operand address
			8'h00: op_decoder_out = mc_add;
			// store the accumulator at the operand address
			8'h01: op_decoder_out = mc_store;
			// load from the operand address
			8'h02: op_decoder_out = mc_load;
			// unconditional branch
			8'h03: op_decoder_out = mc_taken;
			// branch if negative
			8'h04: op_decoder_out = flags[negative_flag] ? mc_taken : mc_not_taken;
			// subtract the byte at the operand address
			8'h05: op_decoder_out = mc_sub;
			8'h06: op_decoder_out = mc_xor;
			8'h07: op_decoder_out = mc_nor;
			8'h08: op_decoder_out = mc_nand;
			// branch if positive, the negative test inverted
			8'h09: op_decoder_out = flags[negative_flag] ? mc_not_taken : mc_taken;
			// branch if zero
			8'h0a: op_decoder_out = flags[zero_flag] ? mc_taken : mc_not_taken;
			// add the immediate byte
			8'h0b: op_decoder_out = mc_add_imm;
			// 8'h0c is left undefined and halts the core
			8'h0d: op_decoder_out = mc_asl;
			8'h0e: op_decoder_out = mc_asr;
			// branch if carry
			8'h70: op_decoder_out = flags[carry_flag] ? mc_taken : mc_not_taken;
			// branch if overflow
			8'h71: op_decoder_out = flags[overflow_flag] ? mc_taken : mc_not_taken;
			8'h72: op_decoder_out = mc_inc;
			// compare with the immediate byte
			8'h73: op_decoder_out = mc_cmp_imm;
			// compare with the byte at the operand address
			8'h74: op_decoder_out = mc_cmp;
			8'h75: op_decoder_out = mc_inv;
			8'h7e: op_decoder_out = mc_clear;
			8'h7f: op_decoder_out = mc_load_imm;
			// everything else lands on the halt entry, all ones
			default: op_decoder_out = mc_halt;
		endcase
	end

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

	// ########################################################################
	// ALU flags
	// ########################################################################

	localparam int fwidth = 4;
	localparam int negative_flag = 0;
	localparam int zero_flag = 1;
	localparam int carry_flag = 2;
	localparam int overflow_flag = 3;

	// ########################################################################
	// microcode addressing
	// ########################################################################

	localparam int mc_offset_width = 6;

	// fixed entries, fetch is followed directly by the dispatch word
	localparam logic [mc_offset_width-1:0] mc_fetch = 6'h00;
	localparam logic [mc_offset_width-1:0] mc_dispatch = 6'h01;
	localparam logic [mc_offset_width-1:0] mc_halt = 6'h3f;

	// routine entries that the opcode decoder hands out
	localparam logic [mc_offset_width-1:0] mc_clear = 6'h02;
	localparam logic [mc_offset_width-1:0] mc_load_imm = 6'h03;
	localparam logic [mc_offset_width-1:0] mc_load = 6'h04;
	localparam logic [mc_offset_width-1:0] mc_store = 6'h08;
	localparam logic [mc_offset_width-1:0] mc_add = 6'h0a;
	localparam logic [mc_offset_width-1:0] mc_taken = 6'h0e;
	localparam logic [mc_offset_width-1:0] mc_not_taken = 6'h0f;
	localparam logic [mc_offset_width-1:0] mc_inc = 6'h10;
	localparam logic [mc_offset_width-1:0] mc_cmp_imm = 6'h11;
	localparam logic [mc_offset_width-1:0] mc_cmp = 6'h12;
	localparam logic [mc_offset_width-1:0] mc_sub = 6'h16;
	localparam logic [mc_offset_width-1:0] mc_xor = 6'h1a;
	localparam logic [mc_offset_width-1:0] mc_nor = 6'h1e;
	localparam logic [mc_offset_width-1:0] mc_nand = 6'h22;
	localparam logic [mc_offset_width-1:0] mc_add_imm = 6'h26;
	localparam logic [mc_offset_width-1:0] mc_inv = 6'h27;
	localparam logic [mc_offset_width-1:0] mc_asr = 6'h28;
	localparam logic [mc_offset_width-1:0] mc_asl = 6'h29;

	typedef enum logic [3:0] {
		alu_pass_mem, alu_add, alu_sub, alu_xor, alu_nor, alu_nand,
		alu_inc, alu_inv, alu_asl, alu_asr, alu_clear, alu_cmp
	} alu_op_e;

	// kinds of sequencing word
	localparam logic [1:0] seq_dispatch = 2'd0;
	localparam logic [1:0] seq_jump = 2'd1;
	localparam logic [1:0] seq_halt = 2'd2;

	// ########################################################################
	// microcode word, bit 15 picks the view in both layouts
	// ########################################################################

	typedef struct packed {
		logic mc_is_seq;
		logic [2:0] spare;
		alu_op_e alu_op;
		logic acc_load;
		logic opr_load;
		logic flags_load;
		// high selects the operand register as memory address
		logic mem_addr_sel;
		logic mem_write;
		logic pc_inc;
		logic pc_load;
		logic end_instr;
	} mc_ctrl_t;

	typedef struct packed {
		logic mc_is_seq;
		logic [1:0] seq_kind;
		logic [6:0] spare;
		logic [mc_offset_width-1:0] target;
	} mc_seq_t;

	typedef union packed {
		mc_ctrl_t mc_ctrl;
		mc_seq_t mc_seq;
	} mc_word_t;

	// ########################################################################
	// APB map, bytes 0x000 to 0x0ff are the shared memory
	// ########################################################################

	localparam int apb_addr_width = 12;
	localparam int apb_data_width = 32;
	localparam logic [apb_addr_width-1:0] reg_ctrl = 12'h100;
	localparam logic [apb_addr_width-1:0] reg_acc = 12'h104;
	localparam logic [apb_addr_width-1:0] reg_flags = 12'h108;

endpackage
